// ==== acquisition/adcRangeMonitor.sv ====
`timescale 1ns/1ps

module adcRangeMonitor (
    input  logic               sysClk,
    input  logic               reset,
    input  logic               csrStrobe,
    input  bpmPkg::gpioWord_t  gpioOut,
    input  logic               adcValid,
    input  bpmPkg::adcSample_t adcData0,
    input  bpmPkg::adcSample_t adcData1,
    output logic               acqValid,
    output bpmPkg::acqSample_t acqData0,
    output bpmPkg::acqSample_t acqData1,
    output bpmPkg::gpioWord_t  rangeReadout
);

    localparam int CHANNELS = bpmPkg::ADC_CHANNEL_COUNT;

    bpmPkg::adcSample_t sampleIn [CHANNELS];
    bpmPkg::adcSample_t rangeMin [CHANNELS];
    bpmPkg::adcSample_t rangeMax [CHANNELS];
    logic               channelSelect;
    logic               rangeClear;

    // Sign extension to acquisition width
    function automatic bpmPkg::acqSample_t widenSample(input bpmPkg::adcSample_t sample);
        return {{(bpmPkg::ACQ_SAMPLE_WIDTH-bpmPkg::ADC_SAMPLE_WIDTH)
                 {sample[bpmPkg::ADC_SAMPLE_WIDTH-1]}}, sample};
    endfunction

    assign sampleIn[0] = adcData0;
    assign sampleIn[1] = adcData1;

    //////////////////////////////////////////////////////////////////////
    // Widened sample stage, one cycle
    always_ff @(posedge sysClk) begin
        if (reset) begin
            acqValid <= 1'b0;
        end else begin
            acqValid <= adcValid;
        end
    end

    always_ff @(posedge sysClk) begin
        acqData0 <= widenSample(adcData0);
        acqData1 <= widenSample(adcData1);
    end

    //////////////////////////////////////////////////////////////////////
    // Control register
    assign rangeClear = csrStrobe & gpioOut[31];

    always_ff @(posedge sysClk) begin
        if (reset) begin
            channelSelect <= 1'b0;
        end else if (csrStrobe) begin
            channelSelect <= gpioOut[0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Running range per channel
    always_ff @(posedge sysClk) begin
        for (int ch = 0; ch < CHANNELS; ch++) begin
            if (reset || rangeClear) begin
                // Sample arriving with a clear is dropped
                rangeMin[ch] <= bpmPkg::ADC_SAMPLE_MAX;
                rangeMax[ch] <= bpmPkg::ADC_SAMPLE_MIN;
            end else if (adcValid) begin
                if (sampleIn[ch] < rangeMin[ch]) begin
                    rangeMin[ch] <= sampleIn[ch];
                end
                if (sampleIn[ch] > rangeMax[ch]) begin
                    rangeMax[ch] <= sampleIn[ch];
                end
            end
        end
    end

    // Max in the upper half, min in the lower
    assign rangeReadout = {rangeMax[channelSelect], rangeMin[channelSelect]};

endmodule

// ==== common/bpmPkg.sv ====
package bpmPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    localparam int GPIO_WIDTH         = 32;
    localparam int GPIO_INDEX_WIDTH   = 3;
    localparam int ADC_SAMPLE_WIDTH   = 16;
    localparam int ACQ_SAMPLE_WIDTH   = 32;
    localparam int EVR_TRIGGER_WIDTH  = 8;
    localparam int TRIGGER_BUS_WIDTH  = 7;
    localparam int LED_COUNT          = 8;
    localparam int DIP_SWITCH_WIDTH   = 8;

    //////////////////////////////////////////////////////////////////////
    // Types

    // Signed sample as it arrives from the AXI stream
    typedef logic signed [ADC_SAMPLE_WIDTH-1:0] adcSample_t;
    typedef logic [ACQ_SAMPLE_WIDTH-1:0]        acqSample_t;
    typedef logic [GPIO_WIDTH-1:0]              gpioWord_t;

    // Bit 0 soft trigger, bits 6:1 event triggers 7:2
    typedef logic [TRIGGER_BUS_WIDTH-1:0]       triggerBus_t;

    // Bit 0 heartbeat, bit 1 pulse per second
    typedef logic [EVR_TRIGGER_WIDTH-1:0]       evrTriggers_t;
    typedef logic [GPIO_INDEX_WIDTH-1:0]        gpioIndex_t;

    //////////////////////////////////////////////////////////////////////
    // Register map
    localparam gpioIndex_t GPIO_IDX_FIRMWARE_BUILD_DATE = 3'd0;
    localparam gpioIndex_t GPIO_IDX_USER_GPIO_CSR       = 3'd1;
    localparam gpioIndex_t GPIO_IDX_SOFT_TRIGGER        = 3'd2;
    localparam gpioIndex_t GPIO_IDX_INTERLOCK_CSR       = 3'd3;
    localparam gpioIndex_t GPIO_IDX_CLK_SPI_MUX_CSR     = 3'd4;
    localparam gpioIndex_t GPIO_IDX_ADC_RANGE_CSR       = 3'd5;
    localparam int         GPIO_IDX_COUNT               = 6;

    localparam gpioWord_t FIRMWARE_BUILD_DATE = 32'h20240611;

    //////////////////////////////////////////////////////////////////////
    // Acquisition and trigger constants
    localparam int ADC_CHANNEL_COUNT = 2;

    // Top bit of the counter is the stretched pulse
    localparam int SOFT_TRIGGER_COUNTER_WIDTH = 4;

    // Range monitor reset values
    localparam adcSample_t ADC_SAMPLE_MAX = {1'b0, {(ADC_SAMPLE_WIDTH-1){1'b1}}};
    localparam adcSample_t ADC_SAMPLE_MIN = {1'b1, {(ADC_SAMPLE_WIDTH-1){1'b0}}};

endpackage

// ==== design/bpmControlTop.sv ====
`timescale 1ns/1ps

module bpmControlTop (
    input  logic                                  sysClk,
    input  logic                                  reset,

    // Processor register bank
    input  bpmPkg::gpioWord_t                     gpioOut,
    input  logic [bpmPkg::GPIO_IDX_COUNT-1:0]     gpioStrobes,
    input  bpmPkg::gpioIndex_t                    gpioReadAddr,
    output bpmPkg::gpioWord_t                     gpioReadData,

    // Event receiver trigger bus
    input  bpmPkg::evrTriggers_t                  evrTriggerBus,

    // Front panel and board controls
    input  logic                                  gpioSwW,
    input  logic                                  gpioSwE,
    input  logic                                  gpioSwN,
    input  logic [bpmPkg::DIP_SWITCH_WIDTH-1:0]   dipSwitch,
    output logic [bpmPkg::LED_COUNT-1:0]          gpioLeds,

    // ADC sample stream
    input  logic                                  adcValid,
    input  bpmPkg::adcSample_t                    adcData0,
    input  bpmPkg::adcSample_t                    adcData1,

    // Acquisition side
    output bpmPkg::triggerBus_t                   eventTriggerStrobes,
    output logic                                  acqValid,
    output bpmPkg::acqSample_t                    acqData0,
    output bpmPkg::acqSample_t                    acqData1,

    // Clock chip SPI routing
    output logic                                  clkSpiMuxSel0,
    output logic                                  clkSpiMuxSel1
);

    logic              softTrigger;
    bpmPkg::gpioWord_t rangeReadout;

    //////////////////////////////////////////////////////////////////////
    // Trigger pipeline
    softTriggerStretch softTriggerStretch (
        .sysClk(sysClk),
        .reset(reset),
        .triggerStrobe(gpioStrobes[bpmPkg::GPIO_IDX_SOFT_TRIGGER]),
        .softTrigger(softTrigger));

    eventTriggerSync eventTriggerSync (
        .sysClk(sysClk),
        .reset(reset),
        .softTrigger(softTrigger),
        .evrTriggerBus(evrTriggerBus),
        .eventTriggerStrobes(eventTriggerStrobes));

    //////////////////////////////////////////////////////////////////////
    // Sample pipeline
    adcRangeMonitor adcRangeMonitor (
        .sysClk(sysClk),
        .reset(reset),
        .csrStrobe(gpioStrobes[bpmPkg::GPIO_IDX_ADC_RANGE_CSR]),
        .gpioOut(gpioOut),
        .adcValid(adcValid),
        .adcData0(adcData0),
        .adcData1(adcData1),
        .acqValid(acqValid),
        .acqData0(acqData0),
        .acqData1(acqData1),
        .rangeReadout(rangeReadout));

    //////////////////////////////////////////////////////////////////////
    // Board registers and readback
    gpioControlRegs gpioControlRegs (
        .sysClk(sysClk),
        .reset(reset),
        .gpioOut(gpioOut),
        .interlockStrobe(gpioStrobes[bpmPkg::GPIO_IDX_INTERLOCK_CSR]),
        .spiMuxStrobe(gpioStrobes[bpmPkg::GPIO_IDX_CLK_SPI_MUX_CSR]),
        .gpioReadAddr(gpioReadAddr),
        .rangeReadout(rangeReadout),
        .evrTriggerBus(evrTriggerBus),
        .gpioSwW(gpioSwW),
        .gpioSwE(gpioSwE),
        .gpioSwN(gpioSwN),
        .dipSwitch(dipSwitch),
        .gpioReadData(gpioReadData),
        .gpioLeds(gpioLeds),
        .clkSpiMuxSel0(clkSpiMuxSel0),
        .clkSpiMuxSel1(clkSpiMuxSel1));

endmodule

// ==== design/gpioControlRegs.sv ====
`timescale 1ns/1ps

module gpioControlRegs (
    input  logic                                  sysClk,
    input  logic                                  reset,
    input  bpmPkg::gpioWord_t                     gpioOut,
    input  logic                                  interlockStrobe,
    input  logic                                  spiMuxStrobe,
    input  bpmPkg::gpioIndex_t                    gpioReadAddr,
    input  bpmPkg::gpioWord_t                     rangeReadout,
    input  bpmPkg::evrTriggers_t                  evrTriggerBus,
    input  logic                                  gpioSwW,
    input  logic                                  gpioSwE,
    input  logic                                  gpioSwN,
    input  logic [bpmPkg::DIP_SWITCH_WIDTH-1:0]   dipSwitch,
    output bpmPkg::gpioWord_t                     gpioReadData,
    output logic [bpmPkg::LED_COUNT-1:0]          gpioLeds,
    output logic                                  clkSpiMuxSel0,
    output logic                                  clkSpiMuxSel1
);

    // Switch order in the synchronizer: {north, east, west}
    logic [2:0]        switchMeta;
    logic [2:0]        switchSync;
    logic              recoveryModeSwitch;
    logic              displayModeSwitch;
    logic              interlockResetButton;

    logic              interlockRelayControl;
    bpmPkg::gpioWord_t spiMuxSel;

    bpmPkg::gpioWord_t userGpioWord;
    bpmPkg::gpioWord_t interlockWord;

    //////////////////////////////////////////////////////////////////////
    // Front panel switches
    always_ff @(posedge sysClk) begin
        if (reset) begin
            switchMeta <= '0;
            switchSync <= '0;
        end else begin
            switchMeta <= {gpioSwN, gpioSwE, gpioSwW};
            switchSync <= switchMeta;
        end
    end

    assign recoveryModeSwitch   = switchSync[0];
    assign displayModeSwitch    = switchSync[1];
    assign interlockResetButton = switchSync[2];

    //////////////////////////////////////////////////////////////////////
    // Interlock relay and clock SPI mux
    always_ff @(posedge sysClk) begin
        if (reset) begin
            interlockRelayControl <= 1'b0;
            spiMuxSel             <= '0;
        end else begin
            if (interlockStrobe) begin
                interlockRelayControl <= gpioOut[0];
            end
            if (spiMuxStrobe) begin
                spiMuxSel <= gpioOut;
            end
        end
    end

    assign clkSpiMuxSel0 = spiMuxSel[0];
    assign clkSpiMuxSel1 = spiMuxSel[1];

    //////////////////////////////////////////////////////////////////////
    // Status words and LEDs
    assign userGpioWord = {recoveryModeSwitch, displayModeSwitch, 6'b0,
                           evrTriggerBus,
                           8'b0,
                           dipSwitch};

    // No relay sense lines on this board so the relay reads closed
    assign interlockWord = {28'b0, 1'b1,
                                   1'b0,
                                   1'b0,
                                   interlockResetButton};

    // LEDs 3:2 were the seconds counter, now dark
    assign gpioLeds = {interlockResetButton,
                       1'b0,
                       1'b1,
                       interlockRelayControl,
                       2'b00,
                       evrTriggerBus[1:0]};

    //////////////////////////////////////////////////////////////////////
    // Readback, one cycle after the address
    always_ff @(posedge sysClk) begin
        case (gpioReadAddr)
            bpmPkg::GPIO_IDX_FIRMWARE_BUILD_DATE: gpioReadData <= bpmPkg::FIRMWARE_BUILD_DATE;
            bpmPkg::GPIO_IDX_USER_GPIO_CSR:       gpioReadData <= userGpioWord;
            bpmPkg::GPIO_IDX_SOFT_TRIGGER:        gpioReadData <= '0;
            bpmPkg::GPIO_IDX_INTERLOCK_CSR:       gpioReadData <= interlockWord;
            bpmPkg::GPIO_IDX_CLK_SPI_MUX_CSR:     gpioReadData <= spiMuxSel;
            bpmPkg::GPIO_IDX_ADC_RANGE_CSR:       gpioReadData <= rangeReadout;
            default:                              gpioReadData <= '0;
        endcase
    end

endmodule

// ==== dv/bpmControlTb.sv ====
`timescale 1ns/1ps

module bpmControlTb;

    localparam int CLOCK_PERIOD          = 40;
    localparam int DRIVE_DELAY           = 2;
    localparam int RESET_CYCLES          = 5;
    localparam int SOFT_TRIGGER_LATENCY  = 4;
    localparam int EVENT_TRIGGER_LATENCY = 2;
    localparam int STROBE_WINDOW         = 12;
    localparam int ROW_COUNT             = 23;

    typedef enum logic [2:0] {
        ACT_WRITE, ACT_READ, ACT_LEDS, ACT_SOFT,
        ACT_EVENT, ACT_INPUTS, ACT_STREAM, ACT_RANGE
    } action_t;

    // LED and input rows: expected bit 0 is relay control, bits 2:1 the mux selects
    typedef struct packed {
        action_t            action;
        bpmPkg::gpioIndex_t index;
        bpmPkg::gpioWord_t  data;
        bpmPkg::gpioWord_t  expected;
    } stepRow_t;

    localparam stepRow_t STEPS [ROW_COUNT] = '{
        '{ACT_READ,   3'd0, 32'h0000_0000, 32'h2024_0611},
        '{ACT_LEDS,   3'd0, 32'h0000_0000, 32'h0000_0000},
        '{ACT_SOFT,   3'd2, 32'h0000_0000, 32'h0000_0001},
        '{ACT_SOFT,   3'd2, 32'h0000_0000, 32'h0000_0001},
        '{ACT_READ,   3'd2, 32'h0000_0000, 32'h0000_0000},
        '{ACT_EVENT,  3'd0, 32'h0000_0004, 32'h0000_0002},
        '{ACT_EVENT,  3'd0, 32'h0000_0020, 32'h0000_0010},
        '{ACT_EVENT,  3'd0, 32'h0000_0080, 32'h0000_0040},
        '{ACT_INPUTS, 3'd1, 32'h0000_0003, 32'h0000_0000},
        '{ACT_INPUTS, 3'd1, 32'h0000_0001, 32'h0000_0000},
        '{ACT_WRITE,  3'd3, 32'h0000_0001, 32'h0000_0000},
        '{ACT_LEDS,   3'd0, 32'h0000_0000, 32'h0000_0001},
        '{ACT_READ,   3'd3, 32'h0000_0000, 32'h0000_0008},
        '{ACT_WRITE,  3'd4, 32'hA5A5_0003, 32'h0000_0000},
        '{ACT_READ,   3'd4, 32'h0000_0000, 32'hA5A5_0003},
        '{ACT_LEDS,   3'd0, 32'h0000_0000, 32'h0000_0007},
        '{ACT_WRITE,  3'd3, 32'hFFFF_FFFE, 32'h0000_0000},
        '{ACT_WRITE,  3'd4, 32'h0000_0002, 32'h0000_0000},
        '{ACT_LEDS,   3'd0, 32'h0000_0000, 32'h0000_0004},
        '{ACT_READ,   3'd6, 32'h0000_0000, 32'h0000_0000},
        '{ACT_STREAM, 3'd0, 32'd48,        32'h0000_0000},
        '{ACT_STREAM, 3'd1, 32'd48,        32'h0000_0000},
        '{ACT_RANGE,  3'd0, 32'h0000_0000, 32'h0000_0000}
    };

    logic                              sysClk;
    logic                              reset;
    bpmPkg::gpioWord_t                 gpioOut;
    logic [bpmPkg::GPIO_IDX_COUNT-1:0] gpioStrobes;
    bpmPkg::gpioIndex_t                gpioReadAddr;
    bpmPkg::gpioWord_t                 gpioReadData;
    bpmPkg::evrTriggers_t              evrTriggerBus;
    logic                              gpioSwW;
    logic                              gpioSwE;
    logic                              gpioSwN;
    logic [7:0]                        dipSwitch;
    logic [7:0]                        gpioLeds;
    logic                              adcValid;
    bpmPkg::adcSample_t                adcData0;
    bpmPkg::adcSample_t                adcData1;
    bpmPkg::triggerBus_t               eventTriggerStrobes;
    logic                              acqValid;
    bpmPkg::acqSample_t                acqData0;
    bpmPkg::acqSample_t                acqData1;
    logic                              clkSpiMuxSel0;
    logic                              clkSpiMuxSel1;

    // Reference range per channel
    int rangeMin [2];
    int rangeMax [2];

    bpmControlTop dut (.*);

    initial begin
        sysClk = 1'b0;
        forever #(CLOCK_PERIOD / 2) sysClk = ~sysClk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    task automatic nextCycle();
        @(posedge sysClk);
        #DRIVE_DELAY;
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] widenToAcq(input logic signed [15:0] sample);
        return 32'(int'(sample));
    endfunction

    function automatic logic [31:0] expectedRange(input int channel);
        return {16'(rangeMax[channel]), 16'(rangeMin[channel])};
    endfunction

    task automatic writeRegister(input bpmPkg::gpioIndex_t index, input logic [31:0] data);
        gpioOut            = data;
        gpioStrobes[index] = 1'b1;
        nextCycle();
        gpioStrobes = '0;
    endtask

    task automatic readRegister(input bpmPkg::gpioIndex_t index, input logic [31:0] expected);
        gpioReadAddr = index;
        nextCycle();
        compareValue($sformatf("gpioReadData[reg %0d]", index), gpioReadData, expected);
    endtask

    // Strobe must appear at exactly one offset inside the window
    task automatic watchStrobes(input int latency, input logic [6:0] bits, input int window);
        for (int i = 0; i < window; i++) begin
            nextCycle();
            gpioStrobes = '0;
            compareValue("eventTriggerStrobes", 32'(eventTriggerStrobes),
                         (i == latency) ? 32'(bits) : 32'h0);
        end
    endtask

    task automatic checkBoardOutputs(input logic [31:0] code);
        compareValue("gpioLeds", 32'(gpioLeds),
                     {24'b0, gpioSwN, 1'b0, 1'b1, code[0], 2'b00, evrTriggerBus[1:0]});
        compareValue("clkSpiMuxSel", {30'b0, clkSpiMuxSel1, clkSpiMuxSel0}, 32'(code[2:1]));
    endtask

    task automatic applyBoardInputs(input logic [7:0] evrBits, input logic [31:0] code);
        logic [31:0] pattern;
        pattern       = $urandom;
        dipSwitch     = pattern[7:0];
        gpioSwW       = pattern[8];
        gpioSwE       = pattern[9];
        gpioSwN       = pattern[10];
        evrTriggerBus = evrBits;
        repeat (3) nextCycle();
        readRegister(3'd1, {gpioSwW, gpioSwE, 6'b0, evrTriggerBus, 8'b0, dipSwitch});
        readRegister(3'd3, {28'b0, 1'b1, 1'b0, 1'b0, gpioSwN});
        checkBoardOutputs(code);
        gpioSwW = 1'b0;
        gpioSwE = 1'b0;
        gpioSwN = 1'b0;
        repeat (3) nextCycle();
    endtask

    // First cycle carries the clear, so its sample stays out of the range
    task automatic streamSamples(input int channel, input int cycles);
        rangeMin = '{32767, 32767};
        rangeMax = '{-32768, -32768};
        for (int i = 0; i < cycles; i++) begin
            if (i == 0) begin
                gpioOut     = 32'h8000_0000 | 32'(channel);
                gpioStrobes = 6'b10_0000;
            end
            adcValid = (i == 0) || ($urandom % 4 != 0);
            adcData0 = 16'($urandom);
            adcData1 = 16'($urandom);
            nextCycle();
            gpioStrobes = '0;
            compareValue("acqValid", 32'(acqValid), 32'(adcValid));
            if (adcValid) begin
                compareValue("acqData0", acqData0, widenToAcq(adcData0));
                compareValue("acqData1", acqData1, widenToAcq(adcData1));
            end
            if (adcValid && i > 0) begin
                rangeMin[0] = (int'(adcData0) < rangeMin[0]) ? int'(adcData0) : rangeMin[0];
                rangeMax[0] = (int'(adcData0) > rangeMax[0]) ? int'(adcData0) : rangeMax[0];
                rangeMin[1] = (int'(adcData1) < rangeMin[1]) ? int'(adcData1) : rangeMin[1];
                rangeMax[1] = (int'(adcData1) > rangeMax[1]) ? int'(adcData1) : rangeMax[1];
            end
        end
        adcValid = 1'b0;
        readRegister(3'd5, expectedRange(channel));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(32'h99849230));
        reset         = 1'b1;
        gpioOut       = '0;
        gpioStrobes   = '0;
        gpioReadAddr  = '0;
        evrTriggerBus = '0;
        gpioSwW       = 1'b0;
        gpioSwE       = 1'b0;
        gpioSwN       = 1'b0;
        dipSwitch     = '0;
        adcValid      = 1'b0;
        adcData0      = '0;
        adcData1      = '0;
        repeat (RESET_CYCLES) @(posedge sysClk);
        #DRIVE_DELAY;
        reset = 1'b0;
        nextCycle();
        compareValue("eventTriggerStrobes", 32'(eventTriggerStrobes), 32'h0);
        compareValue("acqValid", 32'(acqValid), 32'h0);

        for (int i = 0; i < ROW_COUNT; i++) begin
            case (STEPS[i].action)
                ACT_WRITE: writeRegister(STEPS[i].index, STEPS[i].data);
                ACT_READ:  readRegister(STEPS[i].index, STEPS[i].expected);
                ACT_LEDS:  checkBoardOutputs(STEPS[i].expected);
                ACT_SOFT: begin
                    gpioOut                     = '0;
                    gpioStrobes[STEPS[i].index] = 1'b1;
                    watchStrobes(SOFT_TRIGGER_LATENCY, STEPS[i].expected[6:0], STROBE_WINDOW);
                end
                ACT_EVENT: begin
                    evrTriggerBus = evrTriggerBus | STEPS[i].data[7:0];
                    watchStrobes(EVENT_TRIGGER_LATENCY, STEPS[i].expected[6:0], 8);
                    evrTriggerBus = evrTriggerBus & ~STEPS[i].data[7:0];
                    watchStrobes(-1, 7'h00, 4);
                end
                ACT_INPUTS: applyBoardInputs(STEPS[i].data[7:0], STEPS[i].expected);
                ACT_STREAM: streamSamples(int'(STEPS[i].index[0]), int'(STEPS[i].data));
                default: begin
                    writeRegister(3'd5, 32'(STEPS[i].index[0]));
                    readRegister(3'd5, expectedRange(int'(STEPS[i].index[0])));
                end
            endcase
        end

        $display("Result: PASSED");
        $finish;
    end

    // Budget of 20 cycles per row plus every streamed sample
    initial begin
        int budget;
        budget = ROW_COUNT * 20 + RESET_CYCLES;
        for (int i = 0; i < ROW_COUNT; i++) begin
            if (STEPS[i].action == ACT_STREAM) begin
                budget += int'(STEPS[i].data);
            end
        end
        #(budget * CLOCK_PERIOD);
        $display("Timeout: the test did not finish within %0d clock cycles", budget);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== dv/bpmControl_assertions.sv ====
`timescale 1ns/1ps

module bpmControlAssertions (
    input logic                sysClk,
    input logic                reset,
    input logic                adcValid,
    input logic                acqValid,
    input bpmPkg::acqSample_t  acqData0,
    input bpmPkg::triggerBus_t eventTriggerStrobes
);

    // No strobe bit stays high two cycles running
    strobeSingleCycle: assert property (@(posedge sysClk) disable iff (reset)
        (eventTriggerStrobes & $past(eventTriggerStrobes)) == '0)
        else $error("eventTriggerStrobes bit high for two cycles");

    acqValidLatency: assert property (@(posedge sysClk) disable iff (reset)
        acqValid == $past(adcValid))
        else $error("acqValid does not follow adcValid by one cycle");

    // Upper half is a copy of the sample sign
    acqSignExtend: assert property (@(posedge sysClk) disable iff (reset)
        acqData0[31:16] == {16{acqData0[15]}})
        else $error("acqData0 is not sign extended");

endmodule

bind bpmControlTop bpmControlAssertions assertions (
    .sysClk(sysClk),
    .reset(reset),
    .adcValid(adcValid),
    .acqValid(acqValid),
    .acqData0(acqData0),
    .eventTriggerStrobes(eventTriggerStrobes));

// ==== project.f ====
common/bpmPkg.sv
triggers/softTriggerStretch.sv
triggers/eventTriggerSync.sv
acquisition/adcRangeMonitor.sv
design/gpioControlRegs.sv
design/bpmControlTop.sv
dv/bpmControl_assertions.sv
dv/bpmControlTb.sv

// ==== run.sh ====
#!/bin/sh

LOG=sim.log
BUILD_DIR=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module bpmControlTb --Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0

// ==== triggers/eventTriggerSync.sv ====
`timescale 1ns/1ps

module eventTriggerSync (
    input  logic                 sysClk,
    input  logic                 reset,
    input  logic                 softTrigger,
    input  bpmPkg::evrTriggers_t evrTriggerBus,
    output bpmPkg::triggerBus_t  eventTriggerStrobes
);

    bpmPkg::triggerBus_t triggerBus;
    bpmPkg::triggerBus_t triggerMeta;
    bpmPkg::triggerBus_t triggerSync;
    bpmPkg::triggerBus_t triggerDelayed;

    // Heartbeat and PPS stay off the acquisition bus
    assign triggerBus = {evrTriggerBus[bpmPkg::EVR_TRIGGER_WIDTH-1:2], softTrigger};

    //////////////////////////////////////////////////////////////////////
    // Two-flop synchronizer, delay flop, registered rising edges
    always_ff @(posedge sysClk) begin
        if (reset) begin
            triggerMeta         <= '0;
            triggerSync         <= '0;
            triggerDelayed      <= '0;
            eventTriggerStrobes <= '0;
        end else begin
            triggerMeta         <= triggerBus;
            triggerSync         <= triggerMeta;
            triggerDelayed      <= triggerSync;
            eventTriggerStrobes <= triggerSync & ~triggerDelayed;
        end
    end

endmodule

// ==== triggers/softTriggerStretch.sv ====
`timescale 1ns/1ps

module softTriggerStretch (
    input  logic sysClk,
    input  logic reset,
    input  logic triggerStrobe,
    output logic softTrigger
);

    localparam int COUNTER_WIDTH = bpmPkg::SOFT_TRIGGER_COUNTER_WIDTH;

    logic [COUNTER_WIDTH-1:0] stretchCounter;
    logic                     strobeDelayed;

    // Pulse lasts while the top bit is set
    assign softTrigger = stretchCounter[COUNTER_WIDTH-1];

    // Strobe at edge N gives a pulse over cycles N+1 to N+8
    always_ff @(posedge sysClk) begin
        if (reset) begin
            strobeDelayed  <= 1'b0;
            stretchCounter <= '0;
        end else begin
            strobeDelayed <= triggerStrobe;
            if (strobeDelayed) begin
                // A strobe mid-pulse restarts the full width
                stretchCounter <= '1;
            end else if (softTrigger) begin
                stretchCounter <= stretchCounter - 1'b1;
            end
        end
    end

endmodule
